// File: include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_WIDTH       32
`define REG_ADDR_WIDTH   5
`define OP_CODE_WIDTH    6
`define FUNC_CODE_WIDTH  6
`define IMM_WIDTH        16     // I-type immediate field
`define TARGET_WIDTH     26     // J-type index field
`define LINK_REG         5'd31  // jal destination
`define DMEM_DEPTH       256    // words

// opcode field, instr[31:26]
`define OP_RTYPE  6'b000000
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_ADDI   6'b001000
`define OP_SLTI   6'b001010
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_XORI   6'b001110
`define OP_LUI    6'b001111
`define OP_LW     6'b100011
`define OP_SW     6'b101011

// function field, instr[5:0]
`define FN_JR     6'b001000
`define FN_ADD    6'b100000
`define FN_SUB    6'b100010
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_XOR    6'b100110
`define FN_SLT    6'b101010

`endif

// File: rtl/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,  // also the branch compare
        ALU_AND = 4'd3,
        ALU_OR  = 4'd4,
        ALU_XOR = 4'd5,
        ALU_SLT = 4'd6,  // signed
        ALU_LUI = 4'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        FLOW_SEQ = 3'd0,
        FLOW_BEQ = 3'd1,
        FLOW_BNE = 3'd2,
        FLOW_J   = 3'd3,
        FLOW_JAL = 3'd4,
        FLOW_JR  = 3'd5
    } flow_e;

    // decoder output bundle
    typedef struct packed {
        alu_op_e alu_op;
        flow_e   flow;
        logic    imm_sel;       // immediate as operand b
        logic    imm_zero_ext;  // logical ops zero-extend
        logic    mem_read;
        logic    mem_write;
        logic    wb_en;
        logic    wb_sel_rt;     // dest is rt, not rd
        logic    link;          // pc+4 into r31
    } ctrl_t;

    // register write-back as seen at the top level
    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]     data;
    } wb_t;

endpackage

// File: rtl/control.sv
`include "cpu_consts.svh"

module control (
    input  logic [`OP_CODE_WIDTH-1:0]   opcode,
    input  logic [`FUNC_CODE_WIDTH-1:0] func,
    output cpu_pkg::ctrl_t              ctrl
);

    always_comb begin
        ctrl.alu_op       = cpu_pkg::ALU_NOP;  // unlisted codes stay a no-op
        ctrl.flow         = cpu_pkg::FLOW_SEQ;
        ctrl.imm_sel      = 1'b0;
        ctrl.imm_zero_ext = 1'b0;
        ctrl.mem_read     = 1'b0;
        ctrl.mem_write    = 1'b0;
        ctrl.wb_en        = 1'b0;
        ctrl.wb_sel_rt    = 1'b0;
        ctrl.link         = 1'b0;

        case (opcode)
            `OP_RTYPE: begin
                ctrl.wb_en = 1'b1;
                case (func)
                    `FN_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
                    `FN_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
                    `FN_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
                    `FN_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    `FN_XOR: ctrl.alu_op = cpu_pkg::ALU_XOR;
                    `FN_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
                    `FN_JR: begin
                        ctrl.flow  = cpu_pkg::FLOW_JR;
                        ctrl.wb_en = 1'b0;
                    end
                    default: ctrl.wb_en = 1'b0;  // unknown func
                endcase
            end
            `OP_ADDI, `OP_SLTI: begin
                ctrl.alu_op    = (opcode == `OP_ADDI) ? cpu_pkg::ALU_ADD : cpu_pkg::ALU_SLT;
                ctrl.imm_sel   = 1'b1;
                ctrl.wb_en     = 1'b1;
                ctrl.wb_sel_rt = 1'b1;
            end
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                case (opcode)
                    `OP_ANDI: ctrl.alu_op = cpu_pkg::ALU_AND;
                    `OP_ORI:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    `OP_XORI: ctrl.alu_op = cpu_pkg::ALU_XOR;
                    default:  ctrl.alu_op = cpu_pkg::ALU_LUI;
                endcase
                ctrl.imm_sel      = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.wb_en        = 1'b1;
                ctrl.wb_sel_rt    = 1'b1;
            end
            `OP_LW: begin
                ctrl.alu_op    = cpu_pkg::ALU_ADD;  // base + offset
                ctrl.imm_sel   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_en     = 1'b1;
                ctrl.wb_sel_rt = 1'b1;
            end
            `OP_SW: begin
                ctrl.alu_op    = cpu_pkg::ALU_ADD;
                ctrl.imm_sel   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                ctrl.alu_op = cpu_pkg::ALU_SUB;  // zero flag means equal
                ctrl.flow   = (opcode == `OP_BEQ) ? cpu_pkg::FLOW_BEQ : cpu_pkg::FLOW_BNE;
            end
            `OP_J:   ctrl.flow = cpu_pkg::FLOW_J;
            `OP_JAL: begin
                ctrl.flow  = cpu_pkg::FLOW_JAL;
                ctrl.wb_en = 1'b1;
                ctrl.link  = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        assert (!(ctrl.mem_read && ctrl.mem_write))
            else $error("control: load and store strobes set together");
        assert (!(ctrl.wb_en && ctrl.mem_write))
            else $error("control: store decoded with a register write");
    end

endmodule

// File: rtl/alu.sv
`include "cpu_consts.svh"

module alu (
    input  cpu_pkg::alu_op_e       op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero
);

    logic less;  // signed a < b

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_XOR: result = a ^ b;
            cpu_pkg::ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, less};
            cpu_pkg::ALU_LUI: result = b << (`DATA_WIDTH / 2);  // imm to upper half
            default:          result = '0;                      // ALU_NOP
        endcase
    end

    // equality test for beq/bne after a subtract
    assign zero = (result == '0);

endmodule

// File: rtl/reg_file.sv
`include "cpu_consts.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic [`REG_ADDR_WIDTH-1:0] rt_addr,
    output logic [`DATA_WIDTH-1:0]     rs_data,
    output logic [`DATA_WIDTH-1:0]     rt_data,
    input  logic                       we,
    input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`DATA_WIDTH-1:0]     wr_data
);

    localparam int NUM_REGS = 1 << `REG_ADDR_WIDTH;

    logic [`DATA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin  // r0 is hardwired
            regs[wr_addr] <= wr_data;
        end
    end

    // async reads
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    r0_never_written: assert property (
        @(posedge clk) disable iff (reset) regs[0] == '0
    ) else $error("reg_file: register 0 was modified");

endmodule

// File: rtl/data_mem.sv
`include "cpu_consts.svh"

module data_mem (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`DATA_WIDTH-1:0] addr,
    input  logic                   wr_en,
    input  logic [`DATA_WIDTH-1:0] wr_data,
    output logic [`DATA_WIDTH-1:0] rd_data
);

    localparam int AW = $clog2(`DMEM_DEPTH);

    logic [`DATA_WIDTH-1:0] mem [`DMEM_DEPTH];
    logic [AW-1:0]          word_addr;

    // drop byte offset, upper bits wrap
    assign word_addr = addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[word_addr] <= wr_data;
        end
    end

    assign rd_data = mem[word_addr];  // async read

endmodule

// File: rtl/next_pc.sv
`include "cpu_consts.svh"

module next_pc (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_pkg::flow_e           flow,
    input  logic                     zero,
    input  logic [`IMM_WIDTH-1:0]    imm,
    input  logic [`TARGET_WIDTH-1:0] target,
    input  logic [`DATA_WIDTH-1:0]   rs_data,
    output logic [`DATA_WIDTH-1:0]   pc,
    output logic [`DATA_WIDTH-1:0]   pc_plus4
);

    logic [`DATA_WIDTH-1:0] branch_target;
    logic [`DATA_WIDTH-1:0] jump_target;
    logic [`DATA_WIDTH-1:0] pc_next;

    assign pc_plus4 = pc + `DATA_WIDTH'(4);

    // sign-extended word offset from pc+4
    assign branch_target = pc_plus4 +
        {{(`DATA_WIDTH-`IMM_WIDTH-2){imm[`IMM_WIDTH-1]}}, imm, 2'b00};

    // region bits of pc+4 with the word index
    assign jump_target = {pc_plus4[`DATA_WIDTH-1:`TARGET_WIDTH+2], target, 2'b00};

    always_comb begin
        case (flow)
            cpu_pkg::FLOW_BEQ: pc_next = zero ? branch_target : pc_plus4;
            cpu_pkg::FLOW_BNE: pc_next = zero ? pc_plus4 : branch_target;
            cpu_pkg::FLOW_J,
            cpu_pkg::FLOW_JAL: pc_next = jump_target;
            cpu_pkg::FLOW_JR:  pc_next = rs_data;
            default:           pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    pc_stays_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (pc[1:0] == 2'b00 && (flow != cpu_pkg::FLOW_JR || rs_data[1:0] == 2'b00))
            |=> pc[1:0] == 2'b00
    ) else $error("next_pc: pc lost word alignment");

endmodule

// File: rtl/cpu_core.sv
`include "cpu_consts.svh"

module cpu_core (
    input  logic                   clk,
    input  logic                   reset,
    output logic [`DATA_WIDTH-1:0] pc,
    input  logic [`DATA_WIDTH-1:0] instr,
    output cpu_pkg::wb_t           wb
);

    logic [`OP_CODE_WIDTH-1:0]   opcode;
    logic [`FUNC_CODE_WIDTH-1:0] func;
    logic [`REG_ADDR_WIDTH-1:0]  rs;
    logic [`REG_ADDR_WIDTH-1:0]  rt;
    logic [`REG_ADDR_WIDTH-1:0]  rd;
    logic [`IMM_WIDTH-1:0]       imm;
    logic [`TARGET_WIDTH-1:0]    target;

    cpu_pkg::ctrl_t              ctrl;
    logic [`DATA_WIDTH-1:0]      imm_ext;
    logic [`DATA_WIDTH-1:0]      rs_data;
    logic [`DATA_WIDTH-1:0]      rt_data;
    logic [`DATA_WIDTH-1:0]      alu_b;
    logic [`DATA_WIDTH-1:0]      alu_result;
    logic                        alu_zero;
    logic [`DATA_WIDTH-1:0]      mem_rd_data;
    logic [`DATA_WIDTH-1:0]      pc_plus4;
    logic [`REG_ADDR_WIDTH-1:0]  wr_addr;
    logic [`DATA_WIDTH-1:0]      wr_data;
    logic                        wr_en;

    // instruction fields
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign func   = instr[5:0];
    assign imm    = instr[15:0];
    assign target = instr[25:0];

    assign imm_ext = ctrl.imm_zero_ext ?
        {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm} :
        {{(`DATA_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};

    assign alu_b = ctrl.imm_sel ? imm_ext : rt_data;

    assign wr_addr = ctrl.link ? `LINK_REG : (ctrl.wb_sel_rt ? rt : rd);
    assign wr_data = ctrl.link     ? pc_plus4    :
                     ctrl.mem_read ? mem_rd_data : alu_result;

    // nothing commits while in reset, r0 writes dropped here
    assign wr_en = ctrl.wb_en && (wr_addr != '0) && !reset;

    assign wb.valid = wr_en;
    assign wb.addr  = wr_addr;
    assign wb.data  = wr_data;

    control u_control (.opcode(opcode), .func(func), .ctrl(ctrl));

    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .rs_addr(rs), .rt_addr(rt),
        .rs_data(rs_data), .rt_data(rt_data),
        .we(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    alu u_alu (.op(ctrl.alu_op), .a(rs_data), .b(alu_b), .result(alu_result), .zero(alu_zero));

    data_mem u_data_mem (
        .clk(clk), .reset(reset),
        .addr(alu_result), .wr_en(ctrl.mem_write),
        .wr_data(rt_data), .rd_data(mem_rd_data)
    );

    next_pc u_next_pc (
        .clk(clk), .reset(reset),
        .flow(ctrl.flow), .zero(alu_zero),
        .imm(imm), .target(target), .rs_data(rs_data),
        .pc(pc), .pc_plus4(pc_plus4)
    );

endmodule

// File: tb/tb_cpu.sv
`include "cpu_consts.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_WORDS = 64;
    localparam int MAX_CYCLES = 200;  // per program run

    logic                   clk;
    logic                   reset;
    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] instr;
    cpu_pkg::wb_t           wb;

    logic [31:0] prog [PROG_WORDS];           // instruction memory image
    logic [31:0] m_regs [32];                 // architectural model state
    logic [31:0] m_mem [`DMEM_DEPTH];
    logic [31:0] m_pc;
    int          err_count;
    int          fail_count;
    integer      seed;
    string       test_name;

    cpu_core UUT (.clk(clk), .reset(reset), .pc(pc), .instr(instr), .wb(wb));

    always #50 clk = ~clk;

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // operands in assembly order (op rt, rs, imm)
    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    // every unused slot jumps to itself
    task automatic clear_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i[5:0]] = jump_word(`OP_J, 26'(i));
        end
    endtask

    task automatic put(input logic [5:0] slot, input logic [31:0] word);
        prog[slot] = word;
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            err_count++;
            $display("ERR %0t: [%s] pc is %h, expected %h", $time, test_name, got, expected);
        end
    endtask

    task automatic check_wb(input cpu_pkg::wb_t got, input cpu_pkg::wb_t expected);
        if (got.valid !== expected.valid) begin
            err_count++;
            $display("ERR %0t: [%s] wb.valid is %b, expected %b at pc %h",
                     $time, test_name, got.valid, expected.valid, pc);
        end else if (expected.valid && (got.addr !== expected.addr ||
                                        got.data !== expected.data)) begin
            err_count++;
            $display("ERR %0t: [%s] wb r%0d=%h, expected r%0d=%h at pc %h", $time, test_name,
                     got.addr, got.data, expected.addr, expected.data, pc);
        end
    endtask

    task automatic drive_instr();
        if (pc[1:0] != 2'b00 || pc >= PROG_WORDS * 4) begin
            fail_count++;
            $display("[%s] fetch address %h lies outside the program image", test_name, pc);
            instr = '0;
        end else begin
            instr = prog[pc[7:2]];
        end
    endtask

    // steps the reference model by one instruction and returns the expected write-back
    task automatic model_execute(input logic [31:0] word, output cpu_pkg::wb_t expected);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] ea;
        logic [31:0] pc4;
        logic [31:0] npc;
        logic [31:0] value;
        logic        writes;

        rs     = word[25:21];
        rt     = word[20:16];
        a      = m_regs[rs];
        b      = m_regs[rt];
        sext   = {{16{word[15]}}, word[15:0]};
        zext   = {16'h0000, word[15:0]};
        ea     = a + sext;
        pc4    = m_pc + 32'd4;
        npc    = pc4;
        dest   = rt;
        value  = '0;
        writes = 1'b1;

        case (word[31:26])
            `OP_RTYPE: begin
                dest = word[15:11];
                case (word[5:0])
                    `FN_ADD: value = a + b;
                    `FN_SUB: value = a - b;
                    `FN_AND: value = a & b;
                    `FN_OR:  value = a | b;
                    `FN_XOR: value = a ^ b;
                    `FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_JR: begin
                        writes = 1'b0;
                        npc    = a;
                    end
                    default: writes = 1'b0;
                endcase
            end
            `OP_ADDI: value = a + sext;
            `OP_SLTI: value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            `OP_ANDI: value = a & zext;
            `OP_ORI:  value = a | zext;
            `OP_XORI: value = a ^ zext;
            `OP_LUI:  value = {word[15:0], 16'h0000};
            `OP_LW:   value = m_mem[ea[9:2]];  // wraps at 256 words
            `OP_SW: begin
                writes = 1'b0;
                m_mem[ea[9:2]] = b;
            end
            `OP_BEQ: begin
                writes = 1'b0;
                if (a == b) npc = pc4 + {sext[29:0], 2'b00};
            end
            `OP_BNE: begin
                writes = 1'b0;
                if (a != b) npc = pc4 + {sext[29:0], 2'b00};
            end
            `OP_J: begin
                writes = 1'b0;
                npc    = {pc4[31:28], word[25:0], 2'b00};
            end
            `OP_JAL: begin
                dest  = 5'd31;
                value = pc4;
                npc   = {pc4[31:28], word[25:0], 2'b00};
            end
            default: writes = 1'b0;
        endcase

        expected.valid = writes && (dest != 5'd0);
        expected.addr  = dest;
        expected.data  = value;
        if (expected.valid) m_regs[dest] = value;
        m_pc = npc;
    endtask

    // entered and left 10 ns after a rising edge
    task automatic exec_cycle();
        cpu_pkg::wb_t expected;

        drive_instr();
        #5;
        check_pc(pc, m_pc);
        model_execute(instr, expected);
        check_wb(wb, expected);
        @(posedge clk);
        #10;
    endtask

    task automatic apply_reset();
        cpu_pkg::wb_t idle;

        idle  = '0;
        reset = 1'b1;
        for (int i = 0; i < 32; i++) m_regs[i[4:0]] = '0;
        for (int i = 0; i < `DMEM_DEPTH; i++) m_mem[i[7:0]] = '0;
        m_pc = '0;
        for (int i = 0; i < 16; i++) begin
            drive_instr();
            #5;
            if (i > 0) check_pc(pc, 32'h0);  // pc clears at the first edge
            check_wb(wb, idle);
            @(posedge clk);
            #10;
        end
        reset = 1'b0;
    endtask

    task automatic run_program(input logic [31:0] halt_addr);
        int cycles;

        cycles = 0;
        while (m_pc != halt_addr && cycles < MAX_CYCLES) begin
            exec_cycle();
            cycles++;
        end
        if (m_pc != halt_addr) begin
            fail_count++;
            $display("[%s] timeout, address %h not reached within %0d cycles",
                     test_name, halt_addr, MAX_CYCLES);
        end else begin
            repeat (2) exec_cycle();  // self-jump must hold
        end
    endtask

    task automatic arith_test();
        logic [31:0] x;
        logic [31:0] y;

        test_name = "arith";
        for (int iter = 0; iter < 3; iter++) begin
            x = $random(seed) | 32'h8000_0000;  // negative so slt is signed
            y = $random(seed) & 32'h7fff_ffff;
            clear_program();
            put(0, itype_word(`OP_LUI, 1, 0, x[31:16]));
            put(1, itype_word(`OP_ORI, 1, 1, x[15:0]));
            put(2, itype_word(`OP_LUI, 2, 0, y[31:16]));
            put(3, itype_word(`OP_ORI, 2, 2, y[15:0]));
            put(4, rtype_word(`FN_ADD, 3, 1, 2));
            put(5, rtype_word(`FN_SUB, 4, 1, 2));
            put(6, rtype_word(`FN_AND, 5, 1, 2));
            put(7, rtype_word(`FN_OR, 6, 1, 2));
            put(8, rtype_word(`FN_XOR, 7, 1, 2));
            put(9, rtype_word(`FN_SLT, 8, 1, 2));
            put(10, rtype_word(`FN_SLT, 9, 2, 1));
            put(11, itype_word(`OP_ADDI, 10, 1, 16'hfffb));
            put(12, itype_word(`OP_ANDI, 11, 1, 16'h8f0f));
            put(13, itype_word(`OP_ORI, 12, 2, 16'hf00f));
            put(14, itype_word(`OP_XORI, 13, 1, 16'hffff));
            put(15, itype_word(`OP_SLTI, 14, 1, 16'h8000));
            put(16, itype_word(`OP_SLTI, 15, 0, 16'hffff));  // 0 < -1 only if sign-extended
            put(17, itype_word(`OP_LUI, 16, 0, 16'habcd));
            put(18, rtype_word(`FN_ADD, 17, 3, 4));
            put(19, jump_word(`OP_J, 19));
            apply_reset();
            run_program(32'd76);
        end
    endtask

    task automatic reg0_test();
        test_name = "reg0";
        clear_program();
        put(0, itype_word(`OP_ADDI, 1, 0, 16'h0123));
        put(1, itype_word(`OP_ADDI, 0, 0, 16'h1234));
        put(2, rtype_word(`FN_ADD, 0, 1, 1));
        put(3, itype_word(`OP_LUI, 0, 0, 16'hffff));
        put(4, rtype_word(`FN_ADD, 2, 0, 0));
        put(5, rtype_word(`FN_OR, 3, 0, 1));
        put(6, itype_word(`OP_ADDI, 4, 0, 16'h0000));
        put(7, jump_word(`OP_J, 7));
        apply_reset();
        run_program(32'd28);
    endtask

    task automatic mem_test();
        test_name = "mem";
        clear_program();
        put(0, itype_word(`OP_ADDI, 1, 0, 16'h0040));
        put(1, itype_word(`OP_LUI, 2, 0, 16'h1357));
        put(2, itype_word(`OP_ORI, 2, 2, 16'h9bdf));
        put(3, itype_word(`OP_ADDI, 3, 0, 16'hfffe));
        put(4, itype_word(`OP_SW, 2, 1, 16'h0000));
        put(5, itype_word(`OP_SW, 3, 1, 16'h0004));
        put(6, itype_word(`OP_SW, 3, 0, 16'h03fc));  // last word
        put(7, itype_word(`OP_LW, 4, 1, 16'h0000));
        put(8, itype_word(`OP_LW, 5, 1, 16'h0004));
        put(9, itype_word(`OP_LW, 6, 1, 16'h0008));
        put(10, itype_word(`OP_LW, 7, 0, 16'h03fc));
        put(11, itype_word(`OP_LW, 8, 1, 16'h0400));  // wraps onto 0x40
        put(12, itype_word(`OP_LW, 9, 1, 16'hfffc));
        put(13, itype_word(`OP_SW, 1, 0, 16'h0400));
        put(14, itype_word(`OP_LW, 10, 0, 16'h0000));
        put(15, jump_word(`OP_J, 15));
        apply_reset();
        run_program(32'd60);
    endtask

    task automatic branch_test();
        test_name = "branch";
        clear_program();
        put(0, itype_word(`OP_ADDI, 1, 0, 16'd5));
        put(1, itype_word(`OP_ADDI, 2, 0, 16'd5));
        put(2, itype_word(`OP_ADDI, 3, 0, 16'd7));
        put(3, itype_word(`OP_BEQ, 3, 1, 16'd2));     // not taken
        put(4, itype_word(`OP_BEQ, 2, 1, 16'd1));     // taken forward
        put(5, itype_word(`OP_ADDI, 4, 0, 16'h0bad));
        put(6, itype_word(`OP_BNE, 2, 1, 16'd1));     // not taken
        put(7, itype_word(`OP_ADDI, 5, 0, 16'd1));
        put(8, itype_word(`OP_ADDI, 6, 6, 16'd1));
        put(9, itype_word(`OP_BNE, 3, 6, 16'hfffe));  // backward loop
        put(10, itype_word(`OP_BEQ, 0, 0, 16'd1));
        put(11, itype_word(`OP_ADDI, 4, 0, 16'h0bad));
        put(12, itype_word(`OP_ADDI, 7, 7, 16'd1));
        put(13, itype_word(`OP_SLTI, 8, 7, 16'd3));
        put(14, itype_word(`OP_BEQ, 5, 8, 16'hfffd)); // beq backward
        put(15, jump_word(`OP_J, 15));
        apply_reset();
        run_program(32'd60);
    endtask

    task automatic jump_test();
        test_name = "jump";
        clear_program();
        put(0, itype_word(`OP_ADDI, 1, 0, 16'd3));
        put(1, jump_word(`OP_J, 4));
        put(2, itype_word(`OP_ADDI, 2, 0, 16'h0bad));
        put(3, itype_word(`OP_ADDI, 2, 0, 16'h0bad));
        put(4, jump_word(`OP_JAL, 8));                 // r31 gets 20
        put(5, itype_word(`OP_ADDI, 3, 0, 16'h0055));
        put(6, jump_word(`OP_J, 12));
        put(7, itype_word(`OP_ADDI, 2, 0, 16'h0bad));
        put(8, itype_word(`OP_ADDI, 4, 1, 16'd1));
        put(9, rtype_word(`FN_JR, 0, 31, 0));
        put(10, itype_word(`OP_ADDI, 2, 0, 16'h0bad));
        put(12, jump_word(`OP_J, 12));
        apply_reset();
        run_program(32'd48);
    endtask

    task automatic reset_test();
        test_name = "reset";
        clear_program();
        put(0, itype_word(`OP_ADDI, 1, 0, 16'd9));
        put(1, itype_word(`OP_ADDI, 2, 2, 16'd1));
        put(2, itype_word(`OP_SW, 2, 0, 16'h0008));
        put(3, itype_word(`OP_BNE, 1, 2, 16'hfffd));
        put(4, itype_word(`OP_LW, 3, 0, 16'h0008));
        put(5, jump_word(`OP_J, 5));
        apply_reset();
        repeat (10) exec_cycle();  // stop partway through the loop
        apply_reset();
        run_program(32'd20);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        instr      = '0;
        err_count  = 0;
        fail_count = 0;
        seed       = 32'h145afe21;
        test_name  = "init";
        clear_program();
        @(posedge clk);
        #10;

        arith_test();
        reg0_test();
        mem_test();
        branch_test();
        jump_test();
        reset_test();

        $display("Summary: %0d value errors, %0d other failures", err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
rtl/cpu_pkg.sv
rtl/control.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/data_mem.sv
rtl/next_pc.sv
rtl/cpu_core.sv
tb/tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_cpu -o tb_cpu_sim

output=$(./obj_dir/tb_cpu_sim)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
